/* Makefile */
TOP := rv_core_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/1ps -f compile.f \
		--top-module $(TOP) -Mdir obj_dir -o V$(TOP)

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

/* compile.f */
source/rv_pkg.sv
source/rv_decoder.sv
source/rv_regfile.sv
source/rv_execute.sv
source/rv_hazard.sv
source/rv_core.sv
verification/rv_model_pkg.sv
verification/rv_core_tb.sv

/* source/rv_core.sv */
module rv_core (
    input  logic          clk,
    input  logic          rst_n,
    output rv_pkg::word_t im_addr,
    input  rv_pkg::word_t im_dout,
    output rv_pkg::word_t mem_addr,
    output logic          mem_we,
    output rv_pkg::word_t mem_din,
    input  rv_pkg::word_t mem_dout
);
    import rv_pkg::*;

    word_t    pc_q;
    if_id_t   if_id_q;
    id_ex_t   id_ex_q;
    ex_mem_t  ex_mem_q;
    mem_wb_t  mem_wb_q;

    ctrl_t    dec_ctrl;
    word_t    dec_imm;
    word_t    rf_rd1, rf_rd2;

    word_t    alu_result, store_data, target;
    logic     redirect;
    word_t    mem_fwd, wb_data;

    fwd_sel_e fwd1, fwd2;
    logic     stall, flush;

    assign im_addr = pc_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) pc_q <= RESET_PC;
        else if (flush) pc_q <= target;
        else if (!stall) pc_q <= pc_q + 32'd4;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            if_id_q.pc   <= RESET_PC;
            if_id_q.inst <= NOP_INST;
        end else if (flush) begin
            if_id_q.pc   <= RESET_PC;
            if_id_q.inst <= NOP_INST;
        end else if (!stall) begin
            if_id_q.pc   <= pc_q;
            if_id_q.inst <= im_dout;
        end
    end

    rv_decoder u_decoder (
        .inst (if_id_q.inst),
        .ctrl (dec_ctrl),
        .imm  (dec_imm)
    );

    rv_regfile u_regfile (
        .clk   (clk),
        .rst_n (rst_n),
        .we    (mem_wb_q.rf_we),
        .ra1   (if_id_q.inst.r.rs1),
        .ra2   (if_id_q.inst.r.rs2),
        .wa    (mem_wb_q.rd),
        .wd    (wb_data),
        .rd1   (rf_rd1),
        .rd2   (rf_rd2)
    );

    // Load-use inserts a bubble here while IF/ID holds
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_ex_q <= '0;
        end else if (flush || stall) begin
            id_ex_q <= '0;
        end else begin
            id_ex_q.pc   <= if_id_q.pc;
            id_ex_q.ctrl <= dec_ctrl;
            id_ex_q.rs1  <= if_id_q.inst.r.rs1;
            id_ex_q.rs2  <= if_id_q.inst.r.rs2;
            id_ex_q.rd   <= if_id_q.inst.r.rd;
            id_ex_q.rd1  <= rf_rd1;
            id_ex_q.rd2  <= rf_rd2;
            id_ex_q.imm  <= dec_imm;
        end
    end

    rv_hazard u_hazard (
        .id_rs1    (if_id_q.inst.r.rs1),
        .id_rs2    (if_id_q.inst.r.rs2),
        .ex_rs1    (id_ex_q.rs1),
        .ex_rs2    (id_ex_q.rs2),
        .mem_rd    (ex_mem_q.rd),
        .wb_rd     (mem_wb_q.rd),
        .ex_mem_re (id_ex_q.ctrl.mem_re),
        .mem_rf_we (ex_mem_q.ctrl.rf_we),
        .wb_rf_we  (mem_wb_q.rf_we),
        .ex_rd_we  (id_ex_q.ctrl.rf_we),
        .ex_rd     (id_ex_q.rd),
        .redirect  (redirect),
        .fwd1      (fwd1),
        .fwd2      (fwd2),
        .stall     (stall),
        .flush     (flush)
    );

    // A jump in MEM forwards its link value
    assign mem_fwd = (ex_mem_q.ctrl.wd_sel == WD_PC4) ? ex_mem_q.pc4 : ex_mem_q.alu;

    rv_execute u_execute (
        .ex         (id_ex_q),
        .fwd1       (fwd1),
        .fwd2       (fwd2),
        .mem_fwd    (mem_fwd),
        .wb_fwd     (wb_data),
        .alu_result (alu_result),
        .store_data (store_data),
        .redirect   (redirect),
        .target     (target)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_mem_q <= '0;
        end else begin
            ex_mem_q.ctrl       <= id_ex_q.ctrl;
            ex_mem_q.rd         <= id_ex_q.rd;
            ex_mem_q.alu        <= alu_result;
            ex_mem_q.store_data <= store_data;
            ex_mem_q.pc4        <= id_ex_q.pc + 32'd4;
        end
    end

    assign mem_addr = ex_mem_q.alu;
    assign mem_din  = ex_mem_q.store_data;
    assign mem_we   = ex_mem_q.ctrl.mem_we;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_wb_q <= '0;
        end else begin
            mem_wb_q.rf_we     <= ex_mem_q.ctrl.rf_we;
            mem_wb_q.wd_sel    <= ex_mem_q.ctrl.wd_sel;
            mem_wb_q.rd        <= ex_mem_q.rd;
            mem_wb_q.alu       <= ex_mem_q.alu;
            mem_wb_q.load_data <= mem_dout; // Read is combinational
            mem_wb_q.pc4       <= ex_mem_q.pc4;
        end
    end

    always_comb begin
        case (mem_wb_q.wd_sel)
            WD_PC4:  wb_data = mem_wb_q.pc4;
            WD_MEM:  wb_data = mem_wb_q.load_data;
            default: wb_data = mem_wb_q.alu;
        endcase
    end

endmodule

/* source/rv_decoder.sv */
module rv_decoder (
    input  rv_pkg::inst_u inst,
    output rv_pkg::ctrl_t ctrl,
    output rv_pkg::word_t imm
);
    import rv_pkg::*;

    logic [6:0] funct7;
    logic [2:0] funct3;
    word_t      imm_i, imm_s, imm_b, imm_u, imm_j;

    assign funct7 = inst.r.funct7;
    assign funct3 = inst.r.funct3;

    assign imm_i = {{20{inst.i.imm12[11]}}, inst.i.imm12};
    assign imm_s = {{20{funct7[6]}}, funct7, inst.r.rd};
    assign imm_b = {{19{funct7[6]}}, funct7[6], inst.r.rd[0], funct7[5:0], inst.r.rd[4:1], 1'b0};
    assign imm_u = {funct7, inst.r.rs2, inst.r.rs1, funct3, 12'h000};
    assign imm_j = {{11{funct7[6]}}, funct7[6], inst.r.rs1, funct3, inst.r.rs2[0],
                    funct7[5:0], inst.r.rs2[4:1], 1'b0};

    // Funct7 bit 5 picks SUB or SRA
    function automatic alu_op_e alu_from_funct(input logic [2:0] f3, input logic alt,
                                               input logic allow_sub);
        alu_op_e op;
        case (f3)
            3'b000: begin
                if (alt && allow_sub) op = ALU_SUB;
                else op = ALU_ADD;
            end
            3'b001: op = ALU_SLL;
            3'b010: op = ALU_SLT;
            3'b011: op = ALU_SLTU;
            3'b100: op = ALU_XOR;
            3'b101: begin
                if (alt) op = ALU_SRA;
                else op = ALU_SRL;
            end
            3'b110: op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    always_comb begin
        ctrl = '0;
        imm  = '0;
        case (inst.r.opcode)
            OPC_LUI: begin
                ctrl.rf_we    = 1'b1;
                ctrl.src2_imm = 1'b1;
                ctrl.alu_op   = ALU_PASS_B;
                imm           = imm_u;
            end
            OPC_AUIPC: begin
                ctrl.rf_we    = 1'b1;
                ctrl.src1_pc  = 1'b1;
                ctrl.src2_imm = 1'b1;
                imm           = imm_u;
            end
            OPC_JAL: begin
                ctrl.rf_we    = 1'b1;
                ctrl.wd_sel   = WD_PC4;
                ctrl.src1_pc  = 1'b1;
                ctrl.src2_imm = 1'b1;
                ctrl.jal      = 1'b1;
                imm           = imm_j;
            end
            OPC_JALR: begin
                ctrl.rf_we    = 1'b1;
                ctrl.wd_sel   = WD_PC4;
                ctrl.src2_imm = 1'b1;
                ctrl.jalr     = 1'b1;
                imm           = imm_i;
            end
            OPC_BRANCH: begin
                ctrl.src1_pc  = 1'b1; // ALU forms the target
                ctrl.src2_imm = 1'b1;
                imm           = imm_b;
                case (funct3)
                    3'b000: ctrl.br_type = BR_EQ;
                    3'b001: ctrl.br_type = BR_NE;
                    3'b100: ctrl.br_type = BR_LT;
                    3'b101: ctrl.br_type = BR_GE;
                    3'b110: ctrl.br_type = BR_LTU;
                    3'b111: ctrl.br_type = BR_GEU;
                    default: ctrl = '0;
                endcase
            end
            OPC_LOAD: begin
                ctrl.rf_we    = 1'b1;
                ctrl.wd_sel   = WD_MEM;
                ctrl.src2_imm = 1'b1;
                ctrl.mem_re   = 1'b1;
                imm           = imm_i;
            end
            OPC_STORE: begin
                ctrl.src2_imm = 1'b1;
                ctrl.mem_we   = 1'b1;
                imm           = imm_s;
            end
            OPC_OPIMM: begin
                ctrl.rf_we    = 1'b1;
                ctrl.src2_imm = 1'b1;
                ctrl.alu_op   = alu_from_funct(funct3, funct7[5], 1'b0);
                imm           = imm_i;
            end
            OPC_OP: begin
                ctrl.rf_we  = 1'b1;
                ctrl.alu_op = alu_from_funct(funct3, funct7[5], 1'b1);
            end
            default: ctrl = '0; // Unknown opcode
        endcase
        if (inst.r.rd == '0) ctrl.rf_we = 1'b0;
    end

endmodule

/* source/rv_execute.sv */
module rv_execute (
    input  rv_pkg::id_ex_t   ex,
    input  rv_pkg::fwd_sel_e fwd1,
    input  rv_pkg::fwd_sel_e fwd2,
    input  rv_pkg::word_t    mem_fwd,
    input  rv_pkg::word_t    wb_fwd,
    output rv_pkg::word_t    alu_result,
    output rv_pkg::word_t    store_data,
    output logic             redirect,
    output rv_pkg::word_t    target
);
    import rv_pkg::*;

    word_t      op1, op2;
    word_t      src_a, src_b;
    logic [4:0] shamt;
    logic       taken;

    function automatic word_t fwd_mux(input fwd_sel_e sel, input word_t reg_val,
                                      input word_t mem_val, input word_t wb_val);
        case (sel)
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    assign op1 = fwd_mux(fwd1, ex.rd1, mem_fwd, wb_fwd);
    assign op2 = fwd_mux(fwd2, ex.rd2, mem_fwd, wb_fwd);

    assign src_a = ex.ctrl.src1_pc ? ex.pc : op1;
    assign src_b = ex.ctrl.src2_imm ? ex.imm : op2;
    assign shamt = src_b[4:0];

    always_comb begin
        case (ex.ctrl.alu_op)
            ALU_ADD:    alu_result = src_a + src_b;
            ALU_SUB:    alu_result = src_a - src_b;
            ALU_SLL:    alu_result = src_a << shamt;
            ALU_SLT:    alu_result = {{(XLEN-1){1'b0}}, $signed(src_a) < $signed(src_b)};
            ALU_SLTU:   alu_result = {{(XLEN-1){1'b0}}, src_a < src_b};
            ALU_XOR:    alu_result = src_a ^ src_b;
            ALU_SRL:    alu_result = src_a >> shamt;
            ALU_SRA:    alu_result = word_t'($signed(src_a) >>> shamt);
            ALU_OR:     alu_result = src_a | src_b;
            ALU_AND:    alu_result = src_a & src_b;
            ALU_PASS_B: alu_result = src_b; // LUI
            default:    alu_result = '0;
        endcase
    end

    // Compare always on the forwarded registers
    always_comb begin
        case (ex.ctrl.br_type)
            BR_EQ:   taken = (op1 == op2);
            BR_NE:   taken = (op1 != op2);
            BR_LT:   taken = ($signed(op1) < $signed(op2));
            BR_GE:   taken = ($signed(op1) >= $signed(op2));
            BR_LTU:  taken = (op1 < op2);
            BR_GEU:  taken = (op1 >= op2);
            default: taken = 1'b0;
        endcase
    end

    assign redirect   = taken | ex.ctrl.jal | ex.ctrl.jalr;
    assign target     = ex.ctrl.jalr ? {alu_result[XLEN-1:1], 1'b0} : alu_result;
    assign store_data = op2;

endmodule

/* source/rv_hazard.sv */
module rv_hazard (
    input  rv_pkg::reg_addr_t id_rs1,
    input  rv_pkg::reg_addr_t id_rs2,
    input  rv_pkg::reg_addr_t ex_rs1,
    input  rv_pkg::reg_addr_t ex_rs2,
    input  rv_pkg::reg_addr_t mem_rd,
    input  rv_pkg::reg_addr_t wb_rd,
    input  logic              ex_mem_re,
    input  logic              mem_rf_we,
    input  logic              wb_rf_we,
    input  logic              ex_rd_we,
    input  rv_pkg::reg_addr_t ex_rd,
    input  logic              redirect,
    output rv_pkg::fwd_sel_e  fwd1,
    output rv_pkg::fwd_sel_e  fwd2,
    output logic              stall,
    output logic              flush
);
    import rv_pkg::*;

    logic load_use;

    // Youngest producer wins
    function automatic fwd_sel_e pick_fwd(input reg_addr_t rs,
                                          input logic m_we, input reg_addr_t m_rd,
                                          input logic w_we, input reg_addr_t w_rd);
        if (m_we && m_rd != '0 && m_rd == rs) return FWD_MEM;
        if (w_we && w_rd != '0 && w_rd == rs) return FWD_WB;
        return FWD_REG;
    endfunction

    assign fwd1 = pick_fwd(ex_rs1, mem_rf_we, mem_rd, wb_rf_we, wb_rd);
    assign fwd2 = pick_fwd(ex_rs2, mem_rf_we, mem_rd, wb_rf_we, wb_rd);

    // Load data only exists from WB onward
    assign load_use = ex_mem_re && ex_rd_we && ex_rd != '0 &&
                      (ex_rd == id_rs1 || ex_rd == id_rs2);

    assign flush = redirect;
    assign stall = load_use && !redirect; // redirect wins

endmodule

/* source/rv_pkg.sv */
package rv_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    localparam word_t NOP_INST = 32'h0000_0033; // add x0, x0, x0
    localparam word_t RESET_PC = 32'h0000_0000;

    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } inst_r_t;

    typedef struct packed {
        logic [11:0] imm12;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } inst_i_t;

    // S, B, U and J immediates are pieced together from the r view
    typedef union packed {
        inst_r_t r;
        inst_i_t i;
    } inst_u;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
    } br_type_e;

    typedef enum logic [1:0] {WD_ALU, WD_PC4, WD_MEM} wd_sel_e;

    typedef enum logic [1:0] {FWD_REG, FWD_MEM, FWD_WB} fwd_sel_e;

    // All zero is a bubble
    typedef struct packed {
        logic     rf_we;
        wd_sel_e  wd_sel;
        logic     src1_pc;
        logic     src2_imm;
        alu_op_e  alu_op;
        br_type_e br_type;
        logic     jal;
        logic     jalr;
        logic     mem_we;
        logic     mem_re;
    } ctrl_t;

    typedef struct packed {
        word_t pc;
        inst_u inst;
    } if_id_t;

    typedef struct packed {
        word_t     pc;
        ctrl_t     ctrl;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        word_t     rd1;
        word_t     rd2;
        word_t     imm;
    } id_ex_t;

    typedef struct packed {
        ctrl_t     ctrl;
        reg_addr_t rd;
        word_t     alu;
        word_t     store_data;
        word_t     pc4;
    } ex_mem_t;

    typedef struct packed {
        logic      rf_we;
        wd_sel_e   wd_sel;
        reg_addr_t rd;
        word_t     alu;
        word_t     load_data;
        word_t     pc4;
    } mem_wb_t;

endpackage

/* source/rv_regfile.sv */
module rv_regfile (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              we,
    input  rv_pkg::reg_addr_t ra1,
    input  rv_pkg::reg_addr_t ra2,
    input  rv_pkg::reg_addr_t wa,
    input  rv_pkg::word_t     wd,
    output rv_pkg::word_t     rd1,
    output rv_pkg::word_t     rd2
);
    import rv_pkg::*;

    word_t regs [1:31]; // x0 has no storage

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) regs[i] <= '0;
        end else if (we && wa != '0) begin
            regs[wa] <= wd;
        end
    end

    // Write-first bypass
    assign rd1 = (ra1 == '0) ? '0 : (we && wa == ra1) ? wd : regs[ra1];
    assign rd2 = (ra2 == '0) ? '0 : (we && wa == ra2) ? wd : regs[ra2];

endmodule

/* verification/rv_core_tb.sv */
module rv_core_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import rv_pkg::*;
    import rv_model_pkg::*;

    logic  clk = 1'b0;
    logic  rst_n = 1'b0;
    word_t im_addr, im_dout;
    word_t mem_addr, mem_din, mem_dout;
    logic  mem_we;

    word_t imem [0:255];
    word_t dmem [0:1023];
    int    store_idx = 0;
    int    cycles = 0;
    int    limit = 0;

    rv_core rv_core_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .im_addr  (im_addr),
        .im_dout  (im_dout),
        .mem_addr (mem_addr),
        .mem_we   (mem_we),
        .mem_din  (mem_din),
        .mem_dout (mem_dout)
    );

    always #2 clk = ~clk;

    assign im_dout  = (im_addr < 32'd1024) ? imem[im_addr[9:2]] : SELF_LOOP;
    assign mem_dout = dmem[mem_addr[11:2]];

    always @(posedge clk) begin
        if (mem_we) dmem[mem_addr[11:2]] <= mem_din;
    end

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("ERROR time %0t: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
            abort_run();
        end
    endtask

    // Store stream checked at the falling edge
    always @(negedge clk) begin
        if (!rst_n) begin
            check_value("mem_we", {31'd0, mem_we}, '0);
        end else begin
            if (mem_we && store_idx >= store_addr_q.size()) begin
                $display("Extra store to 0x%08h after all %0d expected stores",
                         mem_addr, store_addr_q.size());
                abort_run();
            end else if (mem_we) begin
                check_value("mem_addr", mem_addr, store_addr_q[store_idx]);
                check_value("mem_din", mem_din, store_data_q[store_idx]);
                store_idx++;
            end
            if (store_idx < store_addr_q.size()) begin
                cycles++;
                if (cycles > limit) begin
                    $display("Timeout after %0d cycles with %0d of %0d stores seen",
                             cycles, store_idx, store_addr_q.size());
                    abort_run();
                end
            end
        end
    end

    initial begin
        build_program();
        run_model();
        for (int i = 0; i < 256; i++) begin
            imem[i] = (i < prog.size()) ? prog[i] : SELF_LOOP;
        end
        for (int i = 0; i < 1024; i++) begin
            dmem[i] = fill_word(word_t'(i * 4));
        end
        limit = 3 * prog.size() + 20; // Worst case a stall or flush per instruction
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("im_addr", im_addr, RESET_PC);
        wait (store_idx == store_addr_q.size());
        repeat (20) @(negedge clk); // Window for a stray store
        $display("Simulation passed");
        $finish;
    end

endmodule

/* verification/rv_model_pkg.sv */
package rv_model_pkg;
    import rv_pkg::*;

    localparam int    RAND_COUNT = 200;
    localparam word_t SELF_LOOP  = 32'h0000_006F; // jal x0, 0

    int    seed;
    word_t prog [$];
    word_t store_addr_q [$];
    word_t store_data_q [$];

    function automatic int unsigned rnd(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    // Initial data memory contents
    function automatic word_t fill_word(input word_t addr);
        return (addr * 32'h9E37_79B9) ^ 32'h5A5A_0F0F;
    endfunction

    // Half the time reuse one of the last three destinations
    function automatic reg_addr_t pick_src(input reg_addr_t recent [3]);
        if (rnd(2) == 0) return recent[rnd(3)];
        return reg_addr_t'(rnd(32));
    endfunction

    function automatic void build_program();
        reg_addr_t   recent [3];
        reg_addr_t   rd, rs1, rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        logic [11:0] daddr;
        logic [12:0] boff;
        logic [20:0] joff;
        int unsigned t;
        seed = 45;
        prog.delete();
        recent = '{5'd1, 5'd2, 5'd3};
        for (int unsigned k = 0; k < RAND_COUNT; k++) begin
            rd    = reg_addr_t'(rnd(31)); // x31 stays free as dump base
            rs1   = pick_src(recent);
            rs2   = pick_src(recent);
            f3    = 3'(rnd(8));
            f7    = (rnd(2) == 0) ? 7'h20 : 7'h00;
            imm   = 12'(rnd(4096));
            daddr = {2'b01, 8'(rnd(256)), 2'b00}; // 0x400 to 0x7fc
            t     = k + 1 + rnd((RAND_COUNT - k < 8) ? RAND_COUNT - k : 8);
            boff  = 13'(4 * (t - k));
            joff  = 21'(4 * (t - k));
            case (rnd(14))
                0, 1, 2, 3: begin
                    f7 = (f3 == 3'd0 || f3 == 3'd5) ? f7 : 7'h00;
                    prog.push_back({f7, rs2, rs1, f3, rd, OPC_OP});
                end
                4, 5, 6: begin
                    if (f3 == 3'd1) imm = {7'h00, imm[4:0]};
                    else if (f3 == 3'd5) imm = {f7, imm[4:0]};
                    prog.push_back({imm, rs1, f3, rd, OPC_OPIMM});
                end
                7:  prog.push_back({imm, rs2, f3, rd, OPC_LUI});
                8:  prog.push_back({imm, rs2, f3, rd, OPC_AUIPC});
                9:  prog.push_back({daddr, 5'd0, 3'b010, rd, OPC_LOAD});
                10: prog.push_back({daddr[11:5], rs2, 5'd0, 3'b010, daddr[4:0], OPC_STORE});
                11: begin
                    if (f3[2:1] == 2'b01) f3[2] = 1'b1; // 2 and 3 are not branches
                    prog.push_back({boff[12], boff[10:5], rs2, rs1, f3, boff[4:1], boff[11],
                                    OPC_BRANCH});
                end
                12: prog.push_back({joff[20], joff[10:1], joff[11], joff[19:12], rd, OPC_JAL});
                default: prog.push_back({12'(4 * t), 5'd0, 3'b000, rd, OPC_JALR});
            endcase
            recent[2] = recent[1];
            recent[1] = recent[0];
            recent[0] = rd;
        end
        // x31 = 0x1000, then x1..x31 and x0 go to 0x800 upward
        prog.push_back({20'h00001, 5'd31, OPC_LUI});
        for (int i = 1; i < 33; i++) begin
            imm = 12'(12'h800 + 4 * (i - 1));
            prog.push_back({imm[11:5], reg_addr_t'(i % 32), 5'd31, 3'b010, imm[4:0], OPC_STORE});
        end
    endfunction

    function automatic word_t alu_model(input logic [2:0] f3, input logic alt,
                                        input word_t a, input word_t b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'd0, $signed(a) < $signed(b)};
            3'd3: return {31'd0, a < b};
            3'd4: return a ^ b;
            3'd5: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input word_t a, input word_t b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    // Architectural run that records the stores in order
    function automatic void run_model();
        word_t x [32];
        word_t mem [word_t];
        word_t pc, next, w, a, b, imm_i, addr, res;
        logic  wr;
        store_addr_q.delete();
        store_data_q.delete();
        x  = '{default: '0};
        pc = RESET_PC;
        while (pc < word_t'(4 * prog.size())) begin
            w     = prog[pc[31:2]];
            a     = x[w[19:15]];
            b     = x[w[24:20]];
            imm_i = {{20{w[31]}}, w[31:20]};
            next  = pc + 32'd4;
            wr    = 1'b1;
            res   = '0;
            case (w[6:0])
                OPC_LUI:   res = {w[31:12], 12'h000};
                OPC_AUIPC: res = pc + {w[31:12], 12'h000};
                OPC_JAL: begin
                    res  = pc + 32'd4;
                    next = pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
                end
                OPC_JALR: begin
                    res  = pc + 32'd4;
                    next = (a + imm_i) & ~32'd1;
                end
                OPC_BRANCH: begin
                    wr = 1'b0;
                    if (branch_taken(w[14:12], a, b))
                        next = pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
                end
                OPC_LOAD: begin
                    addr = a + imm_i;
                    res  = mem.exists(addr) ? mem[addr] : fill_word(addr);
                end
                OPC_STORE: begin
                    wr        = 1'b0;
                    addr      = a + {{20{w[31]}}, w[31:25], w[11:7]};
                    mem[addr] = b;
                    store_addr_q.push_back(addr);
                    store_data_q.push_back(b);
                end
                OPC_OPIMM: res = alu_model(w[14:12], w[30] && w[14:12] == 3'd5, a, imm_i);
                OPC_OP:    res = alu_model(w[14:12], w[30], a, b);
                default:   wr = 1'b0;
            endcase
            if (wr && w[11:7] != 5'd0) x[w[11:7]] = res;
            pc = next;
        end
    endfunction

endpackage
